// ==== render_settings.svh ====
`ifndef RENDER_SETTINGS_SVH
`define RENDER_SETTINGS_SVH

// Playfield grid, counted in tiles
`define GRID_COLS       30
`define GRID_ROWS       14
`define TILE_SIZE       8       // Pixels per tile edge

// Visible area is exactly the grid
`define SCREEN_W        240
`define SCREEN_H        112

`define COLOR_BITS      12      // 4-4-4 RGB
`define FB_ADDR_BITS    15

`define BG_COLOR        12'h000 // Black
`define FOOD_COLOR      12'hccc // Light grey
`define PLAYER_COLOR    12'hff0 // Yellow

// APB byte offsets
`define REG_CTRL        8'h00
`define REG_STATUS      8'h04
`define REG_PLAYER      8'h08
`define REG_FOOD_BASE   8'h40   // One word per grid row, stride 4

`endif

// ==== render_pkg.sv ====
`include "render_settings.svh"

package render_pkg;

    // Pixel and framebuffer word
    typedef logic [`COLOR_BITS-1:0]   color_t;
    typedef logic [`FB_ADDR_BITS-1:0] fb_addr_t;   // row * SCREEN_W + column

    // Grid coordinates
    typedef logic [$clog2(`GRID_COLS)-1:0] col_t;
    typedef logic [$clog2(`GRID_ROWS)-1:0] row_t;

    // Screen coordinates
    typedef logic [$clog2(`SCREEN_W)-1:0] pix_x_t;
    typedef logic [$clog2(`SCREEN_H)-1:0] pix_y_t;

    // Facing of the player sprite
    typedef enum logic [1:0] {RIGHT, LEFT, UP, DOWN} dir_t;

    // Frame sequencer states
    typedef enum logic [1:0] {IDLE, TILES, PLAYER} seq_state_t;

    // One bit per column
    typedef logic [`GRID_COLS-1:0] food_row_t;

endpackage

// ==== apb_regs.sv ====
`timescale 1ns/10ps
`include "render_settings.svh"

module apb_regs import render_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        busy,
    input  logic        frame_done,
    output logic        start_frame,
    output logic        scan_enable,
    output col_t        player_col,
    output row_t        player_row,
    output dir_t        player_dir,
    input  row_t        food_row_sel,
    output food_row_t   food_row
);

    logic       access;                     // APB access phase
    logic       is_ctrl, is_status, is_player, is_food;
    logic [7:0] food_off;
    row_t       food_idx;
    logic       busy_any;
    logic       wr_ok;
    logic       done_flag;
    food_row_t  food_q [`GRID_ROWS];

    assign access   = psel && penable;
    assign busy_any = busy || start_frame;  // Covers the gap before the FSM leaves IDLE

    // Address decode
    assign food_off  = paddr - `REG_FOOD_BASE;
    assign food_idx  = row_t'(food_off[5:2]);
    assign is_ctrl   = (paddr == `REG_CTRL);
    assign is_status = (paddr == `REG_STATUS);
    assign is_player = (paddr == `REG_PLAYER);
    assign is_food   = (paddr >= `REG_FOOD_BASE) && (food_off[7:2] < `GRID_ROWS) &&
                       (paddr[1:0] == 2'b00);

    assign pready  = 1'b1;                  // Zero wait states
    assign pslverr = access && (!(is_ctrl || is_status || is_player || is_food) ||
                     (pwrite && busy_any && (is_player || is_food)));
    assign wr_ok   = access && pwrite && !pslverr;

    // Read mux
    always_comb begin
        prdata = 32'h0;
        if (is_ctrl)
            prdata = {30'h0, scan_enable, 1'b0};    // Start reads back as 0
        else if (is_status)
            prdata = {30'h0, done_flag, busy_any};
        else if (is_player)
            prdata = {14'h0, player_dir, 4'h0, player_row, 3'h0, player_col};
        else if (is_food)
            prdata = {2'b00, food_q[food_idx]};
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            start_frame <= 1'b0;
            scan_enable <= 1'b0;
            done_flag   <= 1'b0;
            player_col  <= '0;
            player_row  <= '0;
            player_dir  <= RIGHT;
            for (int r = 0; r < `GRID_ROWS; r++)
                food_q[r] <= '0;
        end else begin
            // One-cycle start pulse, only when idle
            start_frame <= wr_ok && is_ctrl && pwdata[0] && !busy_any;
            if (wr_ok && is_ctrl)
                scan_enable <= pwdata[1];
            if (start_frame)
                done_flag <= 1'b0;      // New frame clears sticky done
            else if (frame_done)
                done_flag <= 1'b1;
            if (wr_ok && is_player) begin
                player_col <= pwdata[4:0];
                player_row <= pwdata[11:8];
                player_dir <= dir_t'(pwdata[17:16]);
            end
            if (wr_ok && is_food)
                food_q[food_idx] <= pwdata[`GRID_COLS-1:0];
        end
    end

    assign food_row = food_q[food_row_sel];     // Row lookup for the tile pass

    // Master must select before enabling
    a_penable_psel: assert property (@(posedge clock) disable iff (!resetn)
        $rose(penable) |-> psel);

endmodule

// ==== frame_sequencer.sv ====
`timescale 1ns/10ps

module frame_sequencer import render_pkg::*; (
    input  logic clock,
    input  logic resetn,
    input  logic start_frame,
    input  logic tile_done,
    input  logic player_done,
    output logic tile_go,
    output logic player_go,
    output logic busy,
    output logic frame_done
);

    seq_state_t state;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state      <= IDLE;
            tile_go    <= 1'b0;
            player_go  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            tile_go    <= 1'b0;     // Pulses by default
            player_go  <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                IDLE: if (start_frame) begin
                    state   <= TILES;
                    tile_go <= 1'b1;
                end
                TILES: if (tile_done) begin
                    state     <= PLAYER;    // Sprite goes on top of the tiles
                    player_go <= 1'b1;
                end
                PLAYER: if (player_done) begin
                    state      <= IDLE;
                    frame_done <= 1'b1;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Held through the done pulse so STATUS never shows idle without done
    assign busy = (state != IDLE) || frame_done;

    a_tile_done_in_tiles: assert property (@(posedge clock) disable iff (!resetn)
        tile_done |-> state == TILES);

endmodule

// ==== tile_painter.sv ====
`timescale 1ns/10ps
`include "render_settings.svh"

module tile_painter import render_pkg::*; (
    input  logic      clock,
    input  logic      resetn,
    input  logic      go,
    output row_t      food_row_sel,
    input  food_row_t food_row,
    output logic      wr_req,
    output fb_addr_t  wr_addr,
    output color_t    wr_data,
    input  logic      wr_gnt,
    output logic      done
);

    localparam int OFS_BITS = $clog2(`TILE_SIZE);
    localparam int HALF     = `TILE_SIZE / 2;

    row_t                trow;
    col_t                tcol;
    logic [OFS_BITS-1:0] px, py;        // Offsets inside the tile
    logic                last_px, last_py, last_col, last_row;
    logic                dot;
    pix_x_t              pix_x;
    pix_y_t              pix_y;

    assign last_px  = (px == OFS_BITS'(`TILE_SIZE - 1));
    assign last_py  = (py == OFS_BITS'(`TILE_SIZE - 1));
    assign last_col = (tcol == col_t'(`GRID_COLS - 1));
    assign last_row = (trow == row_t'(`GRID_ROWS - 1));

    // Screen position from tile and offset
    assign pix_x   = {tcol, px};
    assign pix_y   = {trow, py};
    assign wr_addr = fb_addr_t'(pix_y * `SCREEN_W + pix_x);

    // 2x2 dot at the tile centre
    assign dot = (px == OFS_BITS'(HALF - 1) || px == OFS_BITS'(HALF)) &&
                 (py == OFS_BITS'(HALF - 1) || py == OFS_BITS'(HALF));

    assign food_row_sel = trow;
    assign wr_data      = (food_row[tcol] && dot) ? `FOOD_COLOR : `BG_COLOR;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_req <= 1'b0;
            done   <= 1'b0;
            trow   <= '0;
            tcol   <= '0;
            px     <= '0;
            py     <= '0;
        end else begin
            done <= wr_req && wr_gnt && last_px && last_py && last_col && last_row;
            if (go) begin
                wr_req <= 1'b1;
                trow   <= '0;
                tcol   <= '0;
                px     <= '0;
                py     <= '0;
            end else if (wr_req && wr_gnt) begin     // Step only on a granted write
                if (!last_px) begin
                    px <= px + 1'b1;
                end else begin
                    px <= '0;
                    if (!last_py) begin
                        py <= py + 1'b1;
                    end else begin
                        py <= '0;
                        if (!last_col) begin
                            tcol <= tcol + 1'b1;
                        end else begin
                            tcol <= '0;
                            if (!last_row)
                                trow <= trow + 1'b1;
                            else
                                wr_req <= 1'b0;     // Whole grid painted
                        end
                    end
                end
            end
        end
    end

endmodule

// ==== player_painter.sv ====
`timescale 1ns/10ps
`include "render_settings.svh"

module player_painter import render_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  logic     go,
    input  col_t     player_col,
    input  row_t     player_row,
    input  dir_t     player_dir,
    output logic     wr_req,
    output fb_addr_t wr_addr,
    output color_t   wr_data,
    input  logic     wr_gnt,
    output logic     done
);

    localparam int OFS_BITS = $clog2(`TILE_SIZE);
    localparam int HALF     = `TILE_SIZE / 2;

    logic [OFS_BITS-1:0] dx, dy;        // Sprite pixel offsets
    logic                last_dx, last_dy;
    logic                mid_x, mid_y;  // Centre band of the sprite
    logic                mouth;
    pix_x_t              pix_x;
    pix_y_t              pix_y;

    assign last_dx = (dx == OFS_BITS'(`TILE_SIZE - 1));
    assign last_dy = (dy == OFS_BITS'(`TILE_SIZE - 1));
    assign mid_x   = (dx == OFS_BITS'(HALF - 1)) || (dx == OFS_BITS'(HALF));
    assign mid_y   = (dy == OFS_BITS'(HALF - 1)) || (dy == OFS_BITS'(HALF));

    // Mouth opens toward the facing direction
    always_comb begin
        case (player_dir)
            RIGHT:   mouth = (dx >= OFS_BITS'(HALF)) && mid_y;
            LEFT:    mouth = (dx <  OFS_BITS'(HALF)) && mid_y;
            UP:      mouth = (dy <  OFS_BITS'(HALF)) && mid_x;
            DOWN:    mouth = (dy >= OFS_BITS'(HALF)) && mid_x;
            default: mouth = 1'b0;
        endcase
    end

    assign pix_x   = {player_col, dx};
    assign pix_y   = {player_row, dy};
    assign wr_addr = fb_addr_t'(pix_y * `SCREEN_W + pix_x);
    assign wr_data = mouth ? `BG_COLOR : `PLAYER_COLOR;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            wr_req <= 1'b0;
            done   <= 1'b0;
            dx     <= '0;
            dy     <= '0;
        end else begin
            done <= wr_req && wr_gnt && last_dx && last_dy;
            if (go) begin
                wr_req <= 1'b1;
                dx     <= '0;
                dy     <= '0;
            end else if (wr_req && wr_gnt) begin
                if (!last_dx) begin
                    dx <= dx + 1'b1;
                end else begin
                    dx <= '0;
                    if (!last_dy)
                        dy <= dy + 1'b1;
                    else
                        wr_req <= 1'b0;     // 64 pixels written
                end
            end
        end
    end

    // Player position must land inside the screen
    a_addr_in_range: assert property (@(posedge clock) disable iff (!resetn)
        wr_req |-> wr_addr < fb_addr_t'(`SCREEN_W * `SCREEN_H));

endmodule

// ==== framebuffer_arbiter.sv ====
`timescale 1ns/10ps
`include "render_settings.svh"

module framebuffer_arbiter import render_pkg::*; (
    input  logic     clock,
    input  logic     p_req,         // Player painter, highest priority
    input  fb_addr_t p_addr,
    input  color_t   p_data,
    output logic     p_gnt,
    input  logic     t_req,         // Tile painter
    input  fb_addr_t t_addr,
    input  color_t   t_data,
    output logic     t_gnt,
    input  logic     rd_req,        // Scan-out, lowest priority
    input  fb_addr_t rd_addr,
    output logic     rd_gnt,
    output color_t   rd_data
);

    // One pixel per word, raster order
    color_t mem [`SCREEN_W * `SCREEN_H];

    // Fixed priority, one client per cycle
    assign p_gnt  = p_req;
    assign t_gnt  = t_req && !p_req;
    assign rd_gnt = rd_req && !p_req && !t_req;

    // Single port, access on the grant edge
    always_ff @(posedge clock) begin
        if (p_gnt)
            mem[p_addr] <= p_data;
        else if (t_gnt)
            mem[t_addr] <= t_data;
        if (rd_gnt)
            rd_data <= mem[rd_addr];    // Valid the cycle after the grant
    end

    // Sequencer runs the two passes one after the other
    a_one_painter: assert property (@(posedge clock)
        !(p_req && t_req));

endmodule

// ==== scan_out.sv ====
`timescale 1ns/10ps
`include "render_settings.svh"

module scan_out import render_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  logic     scan_enable,
    output logic     rd_req,
    output fb_addr_t rd_addr,
    input  logic     rd_gnt,
    input  color_t   rd_data,
    output logic     pixel_valid,
    output pix_x_t   pixel_x,
    output pix_y_t   pixel_y,
    output color_t   pixel_color,
    output logic     frame_start
);

    pix_x_t x;                  // Raster position of the next read
    pix_y_t y;
    logic   last_x, last_y;

    assign last_x = (x == pix_x_t'(`SCREEN_W - 1));
    assign last_y = (y == pix_y_t'(`SCREEN_H - 1));

    assign rd_req  = scan_enable;   // Asks every cycle while enabled
    assign rd_addr = fb_addr_t'(y * `SCREEN_W + x);

    // Raster counters move only when the read is granted
    always_ff @(posedge clock) begin
        if (!resetn) begin
            x <= '0;
            y <= '0;
        end else if (rd_gnt) begin
            if (!last_x) begin
                x <= x + 1'b1;
            end else begin
                x <= '0;
                y <= last_y ? '0 : y + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn) begin
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            pixel_valid <= rd_gnt;
            frame_start <= rd_gnt && (x == '0) && (y == '0);    // First pixel of a frame
        end
    end

    // Coordinates line up with the color returned a cycle later
    always_ff @(posedge clock) begin
        if (rd_gnt) begin
            pixel_x <= x;
            pixel_y <= y;
        end
    end

    assign pixel_color = rd_data;

endmodule

// ==== maze_render_top.sv ====
`timescale 1ns/10ps

module maze_render_top import render_pkg::*; (
    input  logic        clock,
    input  logic        resetn,
    input  logic [7:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        pixel_valid,
    output pix_x_t      pixel_x,
    output pix_y_t      pixel_y,
    output color_t      pixel_color,
    output logic        frame_start
);

    // Control
    logic      start_frame, scan_enable, busy, frame_done;
    logic      tile_go, tile_done, player_go, player_done;
    col_t      player_col;
    row_t      player_row;
    dir_t      player_dir;
    row_t      food_row_sel;
    food_row_t food_row;

    // Framebuffer clients
    logic      p_req, p_gnt, t_req, t_gnt, rd_req, rd_gnt;
    fb_addr_t  p_addr, t_addr, rd_addr;
    color_t    p_data, t_data, rd_data;

    apb_regs u_regs (
        .clock, .resetn, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr, .busy, .frame_done, .start_frame,
        .scan_enable, .player_col, .player_row, .player_dir,
        .food_row_sel, .food_row
    );

    frame_sequencer u_seq (
        .clock, .resetn, .start_frame, .tile_done, .player_done,
        .tile_go, .player_go, .busy, .frame_done
    );

    tile_painter u_tiles (
        .clock, .resetn, .go(tile_go), .food_row_sel, .food_row,
        .wr_req(t_req), .wr_addr(t_addr), .wr_data(t_data), .wr_gnt(t_gnt),
        .done(tile_done)
    );

    player_painter u_player (
        .clock, .resetn, .go(player_go), .player_col, .player_row, .player_dir,
        .wr_req(p_req), .wr_addr(p_addr), .wr_data(p_data), .wr_gnt(p_gnt),
        .done(player_done)
    );

    framebuffer_arbiter u_fb (
        .clock, .p_req, .p_addr, .p_data, .p_gnt, .t_req, .t_addr, .t_data,
        .t_gnt, .rd_req, .rd_addr, .rd_gnt, .rd_data
    );

    scan_out u_scan (
        .clock, .resetn, .scan_enable, .rd_req, .rd_addr, .rd_gnt, .rd_data,
        .pixel_valid, .pixel_x, .pixel_y, .pixel_color, .frame_start
    );

endmodule

// ==== tb_maze_render.sv ====
`timescale 1ns/10ps
`include "render_settings.svh"

module tb_maze_render import render_pkg::*;;

    localparam int CLK_PERIOD    = 8;
    localparam int DRIVE_DLY     = 1;                       // Input skew after the edge
    localparam int PIXELS        = `SCREEN_W * `SCREEN_H;
    localparam int RENDER_CYCLES = PIXELS + 64;             // Tile writes plus sprite writes
    localparam int STALL_LIMIT   = RENDER_CYCLES + 1000;    // Longest scan-out gap
    localparam int SYNC_LIMIT    = PIXELS + STALL_LIMIT;
    localparam int NUM_RENDERS   = 5;
    localparam longint WATCHDOG_NS =
        longint'(NUM_RENDERS) * (RENDER_CYCLES + 3 * PIXELS) * CLK_PERIOD * 2;

    logic        clock, resetn;
    logic [7:0]  paddr;
    logic        psel, penable, pwrite;
    logic [31:0] pwdata, prdata;
    logic        pready, pslverr;
    logic        pixel_valid, frame_start;
    logic [7:0]  pixel_x;
    logic [6:0]  pixel_y;
    logic [11:0] pixel_color;

    // Reference state
    logic [11:0] model [PIXELS];
    logic [29:0] food_map [`GRID_ROWS];
    int          pcol, prow;
    dir_t        pdir;
    logic [15:0] lfsr_state;
    int          errors, n_checks;

    maze_render_top DUT (
        .clock, .resetn, .paddr, .psel, .penable, .pwrite, .pwdata,
        .prdata, .pready, .pslverr,
        .pixel_valid, .pixel_x, .pixel_y, .pixel_color, .frame_start
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] got);
        n_checks++;
        if (expected !== got) begin
            $display("Fail %s expected %0h got %0h", name, expected, got);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clock);
        #DRIVE_DLY;
        paddr   = addr;     // Setup phase
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #DRIVE_DLY;
        penable = 1'b1;     // Access phase
        @(negedge clock);
        err = pslverr;
        check_value("pready", 1, 32'(pready));
        @(posedge clock);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clock);
        #DRIVE_DLY;
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #DRIVE_DLY;
        penable = 1'b1;
        @(negedge clock);
        data = prdata;      // Stable mid access phase
        err  = pslverr;
        check_value("pready", 1, 32'(pready));
        @(posedge clock);
        #DRIVE_DLY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Expected framebuffer after one tile pass and one player pass
    task automatic build_model();
        int  tc, tr, ox, oy;
        logic dot, mouth;
        for (int y = 0; y < `SCREEN_H; y++) begin
            for (int x = 0; x < `SCREEN_W; x++) begin
                tc  = x / `TILE_SIZE;
                tr  = y / `TILE_SIZE;
                ox  = x % `TILE_SIZE;
                oy  = y % `TILE_SIZE;
                dot = (ox == 3 || ox == 4) && (oy == 3 || oy == 4);
                model[y * `SCREEN_W + x] = (food_map[tr][tc] && dot) ? `FOOD_COLOR : `BG_COLOR;
                if (tc == pcol && tr == prow) begin
                    case (pdir)
                        RIGHT:   mouth = (ox >= 4) && (oy == 3 || oy == 4);
                        LEFT:    mouth = (ox <= 3) && (oy == 3 || oy == 4);
                        UP:      mouth = (oy <= 3) && (ox == 3 || ox == 4);
                        default: mouth = (oy >= 4) && (ox == 3 || ox == 4);
                    endcase
                    model[y * `SCREEN_W + x] = mouth ? `BG_COLOR : `PLAYER_COLOR;
                end
            end
        end
    endtask

    function automatic logic [31:0] player_word(input int col, input int row, input dir_t dir);
        return (32'(dir) << 16) | (32'(row) << 8) | 32'(col);
    endfunction

    // New food map and player, then the matching model
    task automatic program_random();
        logic [31:0] v;
        logic        err;
        for (int r = 0; r < `GRID_ROWS; r++) begin
            random_bits(30, v);
            food_map[r] = v[29:0];
            apb_write(`REG_FOOD_BASE + 8'(4 * r), v, err);
            check_value("pslverr", 0, err);
        end
        random_bits(5, v);
        pcol = v % `GRID_COLS;
        random_bits(4, v);
        prow = v % `GRID_ROWS;
        random_bits(2, v);
        pdir = dir_t'(v[1:0]);
        apb_write(`REG_PLAYER, player_word(pcol, prow, pdir), err);
        check_value("pslverr", 0, err);
        build_model();
    endtask

    task automatic wait_done();
        logic [31:0] st;
        logic        err;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[1] && polls < RENDER_CYCLES) begin
            apb_read(`REG_STATUS, st, err);
            polls++;
        end
        if (!st[1]) begin
            $display("Render never reported done in STATUS");
            errors++;
        end
    endtask

    // Follows whole frames from the next frame start, colors optional
    task automatic check_scan(input int frames, input bit with_color);
        int k, idle, total;
        k     = 0;
        idle  = 0;
        total = frames * PIXELS;
        @(negedge clock);
        while (!(pixel_valid && frame_start) && idle < SYNC_LIMIT) begin
            @(negedge clock);
            idle++;
        end
        if (!(pixel_valid && frame_start)) begin
            $display("No frame start appeared on the video output");
            errors++;
        end else begin
            idle = 0;
            while (k < total && idle < STALL_LIMIT) begin
                if (pixel_valid) begin
                    check_value("pixel_x", (k % PIXELS) % `SCREEN_W, 32'(pixel_x));
                    check_value("pixel_y", (k % PIXELS) / `SCREEN_W, 32'(pixel_y));
                    check_value("frame_start", 32'((k % PIXELS) == 0), 32'(frame_start));
                    if (with_color)
                        check_value("pixel_color", 32'(model[k % PIXELS]), 32'(pixel_color));
                    k++;
                    idle = 0;
                end else begin
                    idle++;
                end
                if (k < total)
                    @(negedge clock);
            end
            if (k < total) begin
                $display("Scan-out stalled after %0d pixels", k);
                errors++;
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("Test %0d %s: %s", num, name, (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rd, keep;
        logic        err;
        int          e0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        resetn     = 1'b0;
        lfsr_state = 16'd67;
        errors     = 0;
        n_checks   = 0;
        repeat (4) @(posedge clock);
        #DRIVE_DLY;
        resetn = 1'b1;

        // Reset values and unmapped access
        e0 = errors;
        apb_read(`REG_STATUS, rd, err);
        check_value("STATUS", 0, rd);
        check_value("pslverr", 0, err);
        repeat (16) begin
            @(negedge clock);
            check_value("pixel_valid", 0, 32'(pixel_valid));
        end
        apb_read(8'h20, rd, err);
        check_value("pslverr", 1, err);
        report_test(1, "reset state", e0);

        e0 = errors;
        program_random();
        for (int r = 0; r < `GRID_ROWS; r++) begin
            apb_read(`REG_FOOD_BASE + 8'(4 * r), rd, err);
            check_value("FOOD", 32'(food_map[r]), rd);
        end
        apb_read(`REG_PLAYER, rd, err);
        check_value("PLAYER", player_word(pcol, prow, pdir), rd);
        report_test(2, "register readback", e0);

        // Busy window rejects PLAYER writes
        e0 = errors;
        apb_write(`REG_CTRL, 32'h1, err);
        check_value("pslverr", 0, err);
        apb_read(`REG_STATUS, rd, err);
        check_value("STATUS", 1, rd);
        keep = player_word(pcol, prow, pdir);
        apb_write(`REG_PLAYER, keep ^ 32'h0001_0101, err);
        check_value("pslverr", 1, err);
        apb_read(`REG_PLAYER, rd, err);
        check_value("PLAYER", keep, rd);
        wait_done();
        apb_read(`REG_STATUS, rd, err);
        check_value("STATUS", 2, rd);
        report_test(3, "busy and done", e0);

        e0 = errors;
        apb_write(`REG_CTRL, 32'h2, err);   // Scan on, no start
        check_scan(1, 1'b1);
        report_test(4, "first frame contents", e0);

        e0 = errors;
        for (int f = 0; f < 3; f++) begin
            program_random();
            apb_write(`REG_CTRL, 32'h3, err);
            wait_done();
            check_scan(1, 1'b1);
        end
        report_test(5, "three random frames", e0);

        // Render lands inside the first of two scanned frames
        e0 = errors;
        fork
            begin
                do @(negedge clock); while (!(pixel_valid && frame_start));
                repeat (100) @(posedge clock);
                apb_write(`REG_CTRL, 32'h3, err);
                wait_done();
            end
            check_scan(2, 1'b0);
        join
        report_test(6, "raster order under render", e0);

        $display("Checks %0d, errors %0d", n_checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
render_pkg.sv
apb_regs.sv
frame_sequencer.sv
tile_painter.sv
player_painter.sv
framebuffer_arbiter.sv
scan_out.sv
maze_render_top.sv
tb_maze_render.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the maze renderer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module tb_maze_render -o sim_maze_render
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_maze_render > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1
